// ==== include/devBoard_config.svh ====
`ifndef DEV_BOARD_CONFIG_SVH
`define DEV_BOARD_CONFIG_SVH

// APB bus widths
`define DEV_ADDR_W 8
`define DEV_DATA_W 16

// Board pin counts
`define DEV_LED_W 8
`define DEV_DIP_W 4
`define DEV_IRQ_W 7

`define DEV_SYNC_STAGES 2 // Flops per asynchronous input

// Register map
`define DEV_OFS_LED      8'h00 // Read/write
`define DEV_OFS_DIP      8'h04 // Read only
`define DEV_OFS_IRQ_PEND 8'h08 // Read, write one to clear
`define DEV_OFS_IRQ_MASK 8'h0C // Read/write

`endif

// ==== source/devBoardPkg.sv ====
`include "devBoard_config.svh"

package devBoardPkg;

	// APB side
	typedef logic [`DEV_ADDR_W-1:0] apbAddr_t;
	typedef logic [`DEV_DATA_W-1:0] apbData_t;

	// Peripheral values
	typedef logic [`DEV_LED_W-1:0] ledVal_t; // One bit per LED
	typedef logic [`DEV_DIP_W-1:0] dipVal_t; // One bit per switch

	// Interrupt pins, pending and mask all share this layout
	typedef logic [`DEV_IRQ_W-1:0] irqVec_t;

endpackage

// ==== source/gpioPort.sv ====
`timescale 1ns/1ns
`include "devBoard_config.svh"

module gpioPort (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  ledWr,
	input  devBoardPkg::apbData_t wrData,
	output devBoardPkg::ledVal_t  ledVal,
	output devBoardPkg::ledVal_t  leds,
	input  devBoardPkg::dipVal_t  dipSw,
	output devBoardPkg::dipVal_t  dipVal
);
	import devBoardPkg::*;

	ledVal_t ledReg;
	dipVal_t dipSync [`DEV_SYNC_STAGES]; // Stage 0 samples the pins

	// LED register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ledReg <= '0;
		end else if (ledWr) begin
			ledReg <= wrData[`DEV_LED_W-1:0]; // Low bits only
		end
	end

	// DIP switches are asynchronous to clk
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DEV_SYNC_STAGES; i++) begin
				dipSync[i] <= '0;
			end
		end else begin
			dipSync[0] <= dipSw;
			for (int i = 1; i < `DEV_SYNC_STAGES; i++) begin
				dipSync[i] <= dipSync[i-1];
			end
		end
	end

	assign leds   = ledReg;
	assign ledVal = ledReg; // Read-back path to the decoder
	assign dipVal = dipSync[`DEV_SYNC_STAGES-1];

	// The pins move only after a decoded LED write
	ledsOnlyAfterWrite: assert property (
		@(posedge clk) disable iff (!rstN)
		!$stable(leds) |-> $past(ledWr)
	) else $error("leds changed without a preceding ledWr");

endmodule

// ==== source/irqController.sv ====
`timescale 1ns/1ns
`include "devBoard_config.svh"

module irqController (
	input  logic                  clk,
	input  logic                  rstN,
	input  devBoardPkg::irqVec_t  intPins,
	input  logic                  pendClr,
	input  logic                  maskWr,
	input  devBoardPkg::apbData_t wrData,
	output devBoardPkg::irqVec_t  irqPend,
	output devBoardPkg::irqVec_t  irqMask,
	output logic                  irq
);
	import devBoardPkg::*;

	irqVec_t pinSync [`DEV_SYNC_STAGES];
	irqVec_t pinPrev;  // Last synchronized pin levels
	irqVec_t riseEdge;
	irqVec_t clrBits;
	irqVec_t pendReg;
	irqVec_t maskReg;

	// Pin synchronizers and edge history
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DEV_SYNC_STAGES; i++) begin
				pinSync[i] <= '0;
			end
			pinPrev <= '0;
		end else begin
			pinSync[0] <= intPins;
			for (int i = 1; i < `DEV_SYNC_STAGES; i++) begin
				pinSync[i] <= pinSync[i-1];
			end
			pinPrev <= pinSync[`DEV_SYNC_STAGES-1];
		end
	end

	// Low to high on the synchronized level
	assign riseEdge = pinSync[`DEV_SYNC_STAGES-1] & ~pinPrev;

	// Write one to clear
	assign clrBits = pendClr ? wrData[`DEV_IRQ_W-1:0] : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pendReg <= '0;
		end else begin
			// New edge wins over a clear on the same bit
			pendReg <= (pendReg & ~clrBits) | riseEdge;
		end
	end

	// Mask register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			maskReg <= '0;
		end else if (maskWr) begin
			maskReg <= wrData[`DEV_IRQ_W-1:0];
		end
	end

	assign irqPend = pendReg;
	assign irqMask = maskReg;
	assign irq     = |(pendReg & maskReg); // Combinational request

	// Writing an all-zero mask silences the request
	irqQuietWhenMasked: assert property (
		@(posedge clk) disable iff (!rstN)
		(maskWr && (wrData[`DEV_IRQ_W-1:0] == '0)) |=> !irq
	) else $error("irq high with all interrupts masked");

endmodule

// ==== source/apbRegDecoder.sv ====
`timescale 1ns/1ns
`include "devBoard_config.svh"

module apbRegDecoder (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  devBoardPkg::apbAddr_t paddr,
	input  devBoardPkg::apbData_t pwdata,
	output devBoardPkg::apbData_t prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  ledWr,
	output logic                  pendClr,
	output logic                  maskWr,
	output devBoardPkg::apbData_t wrData,
	input  devBoardPkg::ledVal_t  ledVal,
	input  devBoardPkg::dipVal_t  dipVal,
	input  devBoardPkg::irqVec_t  irqPend,
	input  devBoardPkg::irqVec_t  irqMask
);
	import devBoardPkg::*;

	logic access;   // Second cycle of a transfer
	logic selLed;
	logic selDip;
	logic selPend;
	logic selMask;
	logic mapped;
	logic wrAccess;

	assign access = psel & penable;

	// Address match per register
	assign selLed  = (paddr == `DEV_OFS_LED);
	assign selDip  = (paddr == `DEV_OFS_DIP);
	assign selPend = (paddr == `DEV_OFS_IRQ_PEND);
	assign selMask = (paddr == `DEV_OFS_IRQ_MASK);
	assign mapped  = selLed | selDip | selPend | selMask;

	// No wait states, so every access completes here
	assign pready  = access;
	assign pslverr = access & ~mapped;

	// One-cycle strobes; DIP writes fall through and are dropped
	assign wrAccess = access & pwrite;
	assign ledWr    = wrAccess & selLed;
	assign pendClr  = wrAccess & selPend;
	assign maskWr   = wrAccess & selMask;
	assign wrData   = pwdata;

	// Read mux, zero-extended
	always_comb begin
		prdata = '0;
		if (selLed)  prdata = apbData_t'(ledVal);
		if (selDip)  prdata = apbData_t'(dipVal);
		if (selPend) prdata = apbData_t'(irqPend);
		if (selMask) prdata = apbData_t'(irqMask);
	end

	// Slave response is confined to the access phase
	respOnlyInAccess: assert property (
		@(posedge clk) disable iff (!rstN)
		!(psel && penable) |-> !pready && !pslverr
	) else $error("pready or pslverr outside an access phase");

	writeStrobesOneHot: assert property (
		@(posedge clk) disable iff (!rstN)
		$onehot0({ledWr, pendClr, maskWr})
	) else $error("More than one register write strobe");

endmodule

// ==== source/devBoard.sv ====
`timescale 1ns/1ns
`include "devBoard_config.svh"

module devBoard (
	input  logic                  clk,
	input  logic                  rstN,
	// APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  devBoardPkg::apbAddr_t paddr,
	input  devBoardPkg::apbData_t pwdata,
	output devBoardPkg::apbData_t prdata,
	output logic                  pready,
	output logic                  pslverr,
	// Board pins
	output devBoardPkg::ledVal_t  leds,
	input  devBoardPkg::dipVal_t  dipSw,
	input  devBoardPkg::irqVec_t  intPins,
	output logic                  irq
);
	import devBoardPkg::*;

	logic     ledWr;
	logic     pendClr;
	logic     maskWr;
	apbData_t wrData;   // Shared write data to both peripherals
	ledVal_t  ledVal;
	dipVal_t  dipVal;
	irqVec_t  irqPend;
	irqVec_t  irqMask;

	apbRegDecoder u_apbRegDecoder (
		.clk     (clk),
		.rstN    (rstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.ledWr   (ledWr),
		.pendClr (pendClr),
		.maskWr  (maskWr),
		.wrData  (wrData),
		.ledVal  (ledVal),
		.dipVal  (dipVal),
		.irqPend (irqPend),
		.irqMask (irqMask)
	);

	gpioPort u_gpioPort (
		.clk    (clk),
		.rstN   (rstN),
		.ledWr  (ledWr),
		.wrData (wrData),
		.ledVal (ledVal),
		.leds   (leds),
		.dipSw  (dipSw),
		.dipVal (dipVal)
	);

	irqController u_irqController (
		.clk     (clk),
		.rstN    (rstN),
		.intPins (intPins),
		.pendClr (pendClr),
		.maskWr  (maskWr),
		.wrData  (wrData),
		.irqPend (irqPend),
		.irqMask (irqMask),
		.irq     (irq)
	);

endmodule

// ==== tb/devBoardTb.sv ====
`timescale 1ns/1ns
`include "devBoard_config.svh"

module devBoardTb;
	import devBoardPkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int TIMEOUT_CYCLES = 2000; // Directed tests need a few hundred

	logic     clk;
	logic     rstN;
	logic     psel;
	logic     penable;
	logic     pwrite;
	apbAddr_t paddr;
	apbData_t pwdata;
	apbData_t prdata;
	logic     pready;
	logic     pslverr;
	ledVal_t  leds;
	dipVal_t  dipSw;
	irqVec_t  intPins;
	logic     irq;

	// Expected register contents
	ledVal_t expLed;
	irqVec_t expPend;
	irqVec_t expMask;

	int cycleCount = 0;
	int errorCount = 0;

	devBoard u_devBoard (
		.clk     (clk),
		.rstN    (rstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.leds    (leds),
		.dipSw   (dipSw),
		.intPins (intPins),
		.irq     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", cycleCount);
			$display("Simulation failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic stopOnMismatch(input string what);
		errorCount++;
		$display("Mismatch at time %0t: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic checkLed(input ledVal_t got, input ledVal_t exp, input string what);
		if (got !== exp) begin
			stopOnMismatch($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkDip(input dipVal_t got, input dipVal_t exp, input string what);
		if (got !== exp) begin
			stopOnMismatch($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkIrqVec(input irqVec_t got, input irqVec_t exp, input string what);
		if (got !== exp) begin
			stopOnMismatch($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic checkData(input apbData_t got, input apbData_t exp, input string what);
		if (got !== exp) begin
			stopOnMismatch($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stopOnMismatch($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	// One APB transfer through setup and access with outputs sampled mid-cycle
	task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t data,
			output apbData_t rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		#(CLK_PERIOD/4);
		checkBit(pready, 1'b0, "pready in setup phase");
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD/4);
		checkBit(pready, 1'b1, "pready in access phase");
		rdata = prdata;
		err   = pslverr;
		@(negedge clk); // Rising edge in between ended the access
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		#(CLK_PERIOD/4);
		checkBit(pready, 1'b0, "pready while idle");
		checkBit(pslverr, 1'b0, "pslverr while idle");
	endtask

	task automatic apbWrite(input apbAddr_t addr, input apbData_t data, output logic err);
		apbData_t unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err);
		apbTransfer(1'b0, addr, apbData_t'($urandom), data, err); // pwdata is noise
	endtask

	task automatic verifyResetState();
		apbData_t rd;
		logic     err;
		checkLed(leds, '0, "leds after reset");
		checkBit(irq, 1'b0, "irq after reset");
		apbRead(`DEV_OFS_LED, rd, err);
		checkBit(err, 1'b0, "pslverr on LED read");
		checkData(rd, '0, "LED register after reset");
		apbRead(`DEV_OFS_IRQ_PEND, rd, err);
		checkData(rd, '0, "pending register after reset");
		apbRead(`DEV_OFS_IRQ_MASK, rd, err);
		checkData(rd, '0, "mask register after reset");
	endtask

	task automatic exerciseLeds();
		apbData_t values [12];
		apbData_t rd;
		logic     err;
		values[0] = 16'h00AA;
		values[1] = 16'h0055;
		for (int i = 2; i < 12; i++) begin
			values[i] = apbData_t'($urandom); // Upper byte must be ignored
		end
		// Unmapped offset
		apbWrite(8'h10, 16'h00AA, err);
		checkBit(err, 1'b1, "pslverr on unmapped write");
		checkLed(leds, expLed, "leds after unmapped write");
		apbRead(8'h10, rd, err);
		checkBit(err, 1'b1, "pslverr on unmapped read");
		for (int i = 0; i < 12; i++) begin
			apbWrite(`DEV_OFS_LED, values[i], err);
			checkBit(err, 1'b0, "pslverr on LED write");
			expLed = values[i][`DEV_LED_W-1:0];
			checkLed(leds, expLed, $sformatf("leds after write %0d", i));
			apbRead(`DEV_OFS_LED, rd, err);
			checkData(rd, apbData_t'(expLed), $sformatf("LED read-back %0d", i));
		end
	endtask

	task automatic sampleDipSwitches();
		dipVal_t  sw;
		apbData_t rd;
		logic     err;
		for (int i = 0; i < 8; i++) begin
			sw = dipVal_t'($urandom);
			@(negedge clk);
			dipSw = sw;
			repeat (`DEV_SYNC_STAGES + 1) @(negedge clk); // Past the synchronizer
			apbRead(`DEV_OFS_DIP, rd, err);
			checkBit(err, 1'b0, "pslverr on DIP read");
			checkDip(rd[`DEV_DIP_W-1:0], sw, "DIP read-back");
			checkData(rd, apbData_t'(sw), "DIP word zero-extended");
		end
		// Read-only register
		apbWrite(`DEV_OFS_DIP, 16'hFFFF, err);
		checkBit(err, 1'b0, "pslverr on DIP write");
		apbRead(`DEV_OFS_DIP, rd, err);
		checkDip(rd[`DEV_DIP_W-1:0], sw, "DIP after write attempt");
		checkLed(leds, expLed, "leds after DIP write");
		apbRead(`DEV_OFS_IRQ_MASK, rd, err);
		checkIrqVec(rd[`DEV_IRQ_W-1:0], expMask, "mask after DIP write");
	endtask

	task automatic captureInterrupts();
		irqVec_t  pins;
		apbData_t rd;
		logic     err;
		for (int i = 0; i < 6; i++) begin
			pins = irqVec_t'($urandom);
			if (pins == '0) begin
				pins[0] = 1'b1;
			end
			@(negedge clk);
			intPins = pins;
			repeat (`DEV_SYNC_STAGES + 2) @(negedge clk);
			expPend = expPend | pins;
			apbRead(`DEV_OFS_IRQ_PEND, rd, err);
			checkIrqVec(rd[`DEV_IRQ_W-1:0], expPend, "pending after rising pins");
			checkBit(irq, 1'b0, "irq with mask zero");
			// Clear while the pins stay high
			apbWrite(`DEV_OFS_IRQ_PEND, apbData_t'(pins), err);
			expPend = expPend & ~pins;
			repeat (4) @(negedge clk);
			apbRead(`DEV_OFS_IRQ_PEND, rd, err);
			checkIrqVec(rd[`DEV_IRQ_W-1:0], expPend, "pending with pins held high");
			@(negedge clk);
			intPins = '0;
			repeat (`DEV_SYNC_STAGES + 2) @(negedge clk);
			apbRead(`DEV_OFS_IRQ_PEND, rd, err);
			checkIrqVec(rd[`DEV_IRQ_W-1:0], expPend, "pending after falling pins");
		end
	endtask

	task automatic maskAndClearIrq();
		irqVec_t  pendSet;
		irqVec_t  maskVal;
		irqVec_t  clrVal;
		apbData_t rd;
		logic     err;
		int       pin;
		pendSet = irqVec_t'($urandom);
		pendSet[`DEV_IRQ_W-1] = 1'b0; // Top pin stays idle
		pendSet[0] = 1'b1;
		@(negedge clk);
		intPins = pendSet;
		repeat (`DEV_SYNC_STAGES + 2) @(negedge clk);
		expPend = expPend | pendSet;
		checkBit(irq, 1'b0, "irq with bits pending and mask zero");
		// Mask only idle pins
		maskVal = ~pendSet;
		apbWrite(`DEV_OFS_IRQ_MASK, apbData_t'(maskVal), err);
		expMask = maskVal;
		checkBit(irq, 1'b0, "irq with mask missing every pending bit");
		apbRead(`DEV_OFS_IRQ_MASK, rd, err);
		checkIrqVec(rd[`DEV_IRQ_W-1:0], expMask, "mask read-back");
		maskVal = expMask;
		maskVal[0] = 1'b1;
		apbWrite(`DEV_OFS_IRQ_MASK, apbData_t'(maskVal), err);
		expMask = maskVal;
		checkBit(irq, 1'b1, "irq with a pending bit unmasked");
		// Clear exactly what the mask lets through
		clrVal = expPend & expMask;
		apbWrite(`DEV_OFS_IRQ_PEND, apbData_t'(clrVal), err);
		expPend = expPend & ~clrVal;
		checkBit(irq, 1'b0, "irq after clearing unmasked bits");
		apbRead(`DEV_OFS_IRQ_PEND, rd, err);
		checkIrqVec(rd[`DEV_IRQ_W-1:0], expPend, "pending after clear");

		@(negedge clk);
		intPins = '0;
		repeat (`DEV_SYNC_STAGES + 2) @(negedge clk);
		apbWrite(`DEV_OFS_IRQ_PEND, 16'hFFFF, err);
		expPend = '0;
		maskVal = '1;
		apbWrite(`DEV_OFS_IRQ_MASK, apbData_t'(maskVal), err);
		expMask = maskVal;
		checkBit(irq, 1'b0, "irq with nothing pending");
		// Latency of one pin through synchronizer and edge detect
		pin = $urandom_range(`DEV_IRQ_W-1, 0);
		@(negedge clk);
		intPins[pin] = 1'b1;
		repeat (`DEV_SYNC_STAGES) begin
			@(negedge clk);
			checkBit(irq, 1'b0, $sformatf("irq early on pin %0d", pin));
		end
		@(negedge clk);
		expPend[pin] = 1'b1;
		checkBit(irq, 1'b1, $sformatf("irq on time for pin %0d", pin));
		apbWrite(`DEV_OFS_IRQ_PEND, apbData_t'(expPend), err);
		expPend = '0;
		repeat (4) @(negedge clk);
		checkBit(irq, 1'b0, "irq after clear with pin held high");
		@(negedge clk);
		intPins = '0;
	endtask

	initial begin
		void'($urandom(32'h99d8_be19));
		rstN    = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		dipSw   = '0;
		intPins = '0;
		expLed  = '0;
		expPend = '0;
		expMask = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		verifyResetState();
		exerciseLeds();
		sampleDipSwitches();
		captureInterrupts();
		maskAndClearIrq();

		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== devBoard.f ====
+incdir+include
source/devBoardPkg.sv
source/gpioPort.sv
source/irqController.sv
source/apbRegDecoder.sv
source/devBoard.sv
tb/devBoardTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the devBoard testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
PASS_TEXT="Simulation completed successfully"

if ! verilator --binary --timing --assert -f devBoard.f --top-module devBoardTb \
	-Mdir "$BUILD_DIR" -o devBoardSim; then
	echo "ERROR: Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/devBoardSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "ERROR: simulation exited with status $simStatus"
	exit 1
fi

if grep -q "$PASS_TEXT" "$LOG"; then
	echo "RESULT: PASS"
	exit 0
else
	echo "RESULT: FAIL"
	exit 1
fi
